// ==== rtl/asg_pkg.sv ====
// shared types and APB map; table window must hold 2**ADDR_W words below 0x1000
`default_nettype none

package asg_pkg;

  //////////////////////////////
  // data types
  //////////////////////////////

  // signed DAC sample, two's complement
  typedef logic signed [14-1:0] sample_t;

  // APB bus widths
  localparam int unsigned APB_AW = 12;
  localparam int unsigned APB_DW = 32;

  //////////////////////////////
  // register map
  //////////////////////////////

  // control: bit0 sw trigger, bit1 stop, bit2 burst enable, bit3 infinite
  localparam logic [APB_AW-1:0] REG_CTRL     = 12'h000;
  localparam logic [APB_AW-1:0] REG_TRG_MASK = 12'h004;
  // fixed point table size, step and offset
  localparam logic [APB_AW-1:0] REG_SIZ      = 12'h008;
  localparam logic [APB_AW-1:0] REG_STP      = 12'h00c;
  localparam logic [APB_AW-1:0] REG_OFF      = 12'h010;
  // burst data length, period length, repetitions
  localparam logic [APB_AW-1:0] REG_BDL      = 12'h014;
  localparam logic [APB_AW-1:0] REG_BLN      = 12'h018;
  localparam logic [APB_AW-1:0] REG_BNM      = 12'h01c;
  // bit0 running, 31:16 repetition counter
  localparam logic [APB_AW-1:0] REG_STATUS   = 12'h020;

  // table window, entry i at TABLE_BASE + 4*i, write only
  localparam logic [APB_AW-1:0] TABLE_BASE   = 12'h800;

endpackage : asg_pkg

`default_nettype wire

// ==== rtl/asg_table.sv ====
// single clock table; read port and beat descriptor move only when the pipeline advances
`default_nettype none
`timescale 1ns/1ns

module asg_table #(
  parameter int unsigned ADDR_W = 6
) (
  input  logic               sto,
  input  logic               ctl_rst,
  input  logic               advance,
  // host write port
  input  logic               tbl_we,
  input  logic [ADDR_W-1:0]  tbl_waddr,
  input  asg_pkg::sample_t   tbl_wdata,
  // stream read port
  input  logic               rd_en,
  input  logic [ADDR_W-1:0]  rd_addr,
  input  logic               beat_vld,
  input  logic               beat_last,
  output asg_pkg::sample_t   rd_data,
  output logic               data_vld,
  output logic               data_last
);

  import asg_pkg::*;

  sample_t mem [0:2**ADDR_W-1];

  // host write
  always_ff @(posedge sto) begin
    if (tbl_we) begin
      mem[tbl_waddr] <= tbl_wdata;
    end
  end

  // sample holds when rd_en is low, burst idle repeats it
  always_ff @(posedge sto) begin
    if (advance && rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // descriptor kept in step with the sample
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      data_vld  <= 1'b0;
      data_last <= 1'b0;
    end else if (advance) begin
      data_vld  <= beat_vld;
      data_last <= beat_last;
    end
  end

endmodule : asg_table

`default_nettype wire

// ==== rtl/asg_stream_out.sv ====
// last register stage; advance is combinational from tready and tvalid
`default_nettype none
`timescale 1ns/1ns

module asg_stream_out (
  input  logic             sto,
  input  logic             ctl_rst,
  input  logic             stop,
  // from table
  input  asg_pkg::sample_t rd_data,
  input  logic             data_vld,
  input  logic             data_last,
  // stream
  input  logic             tready,
  output asg_pkg::sample_t tdata,
  output logic             tvalid,
  output logic             tlast,
  // beat accepted with last
  output logic             done,
  // pipeline enable for all stages
  output logic             advance
);

  // empty or draining
  assign advance = tready | ~tvalid;

  assign done = tvalid & tready & tlast;

  // payload held while stalled
  always_ff @(posedge sto) begin
    if (advance) begin
      tdata <= rd_data;
    end
  end

  always_ff @(posedge sto) begin
    if (ctl_rst || stop) begin
      tvalid <= 1'b0;
      tlast  <= 1'b0;
    end else if (advance) begin
      tvalid <= data_vld;
      tlast  <= data_last;
    end
  end

endmodule : asg_stream_out

`default_nettype wire

// ==== rtl/asg_apb_regs.sv ====
// APB slave without wait states; settings truncated to width, table window is write only
`default_nettype none
`timescale 1ns/1ns

module asg_apb_regs #(
  parameter int unsigned ADDR_W = 6,
  parameter int unsigned FRAC_W = 8,
  parameter int unsigned CNT_W  = 16,
  parameter int unsigned TRG_N  = 2
) (
  input  logic                           sto,
  input  logic                           ctl_rst,
  // APB slave
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [asg_pkg::APB_AW-1:0]     paddr,
  input  logic [asg_pkg::APB_DW-1:0]     pwdata,
  output logic [asg_pkg::APB_DW-1:0]     prdata,
  output logic                           pready,
  output logic                           pslverr,
  // status from sequencer
  input  logic                           running,
  input  logic [CNT_W-1:0]               rep_cnt,
  // settings
  output logic [ADDR_W+FRAC_W-1:0]       siz,
  output logic [ADDR_W+FRAC_W-1:0]       stp,
  output logic [ADDR_W+FRAC_W-1:0]       off,
  output logic                           burst_en,
  output logic                           infinite,
  output logic [CNT_W-1:0]               bdl,
  output logic [CNT_W-1:0]               bln,
  output logic [CNT_W-1:0]               bnm,
  output logic [TRG_N-1:0]               trg_mask,
  // control pulses
  output logic                           sw_trig,
  output logic                           stop,
  // table write port
  output logic                           tbl_we,
  output logic [ADDR_W-1:0]              tbl_waddr,
  output asg_pkg::sample_t               tbl_wdata
);

  import asg_pkg::*;

  localparam int unsigned PW = ADDR_W + FRAC_W;

  logic apb_acc;
  logic apb_wr;
  logic reg_hit;
  logic tbl_hit;

  //////////////////////////////
  // access decode
  //////////////////////////////

  // access phase only, no wait states
  assign apb_acc = psel & penable;
  assign apb_wr  = apb_acc & pwrite;
  assign pready  = penable;

  // upper address bits select the table window
  assign tbl_hit = (paddr >> (ADDR_W + 2)) == (TABLE_BASE >> (ADDR_W + 2));

  // table reads are not supported
  assign pslverr = apb_acc & (tbl_hit ? ~pwrite : ~reg_hit);

  // table write port, word addressed
  assign tbl_we    = apb_wr & tbl_hit;
  assign tbl_waddr = paddr[2 +: ADDR_W];
  assign tbl_wdata = sample_t'(pwdata[$bits(sample_t)-1:0]);

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    reg_hit = 1'b1;
    prdata  = '0;
    case (paddr)
      REG_CTRL:     prdata = APB_DW'({infinite, burst_en, 2'b00});
      REG_TRG_MASK: prdata = APB_DW'(trg_mask);
      REG_SIZ:      prdata = APB_DW'(siz);
      REG_STP:      prdata = APB_DW'(stp);
      REG_OFF:      prdata = APB_DW'(off);
      REG_BDL:      prdata = APB_DW'(bdl);
      REG_BLN:      prdata = APB_DW'(bln);
      REG_BNM:      prdata = APB_DW'(bnm);
      REG_STATUS: begin
        prdata[0]     = running;
        prdata[31:16] = 16'(rep_cnt);
      end
      default:      reg_hit = 1'b0;
    endcase
  end

  //////////////////////////////
  // setting registers
  //////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      siz      <= '0;
      stp      <= '0;
      off      <= '0;
      burst_en <= 1'b0;
      infinite <= 1'b0;
      bdl      <= '0;
      bln      <= '0;
      bnm      <= '0;
      trg_mask <= '0;
      sw_trig  <= 1'b0;
      stop     <= 1'b0;
    end else begin
      // pulses last a single cycle
      sw_trig <= 1'b0;
      stop    <= 1'b0;
      if (apb_wr) begin
        case (paddr)
          REG_CTRL: begin
            sw_trig  <= pwdata[0];
            stop     <= pwdata[1];
            burst_en <= pwdata[2];
            infinite <= pwdata[3];
          end
          REG_TRG_MASK: trg_mask <= pwdata[TRG_N-1:0];
          REG_SIZ:      siz      <= pwdata[PW-1:0];
          REG_STP:      stp      <= pwdata[PW-1:0];
          REG_OFF:      off      <= pwdata[PW-1:0];
          REG_BDL:      bdl      <= pwdata[CNT_W-1:0];
          REG_BLN:      bln      <= pwdata[CNT_W-1:0];
          REG_BNM:      bnm      <= pwdata[CNT_W-1:0];
          // status is read only, other offsets ignored
          default: ;
        endcase
      end
    end
  end

endmodule : asg_apb_regs

`default_nettype wire

// ==== rtl/asg_sequencer.sv ====
// step must not exceed size and offset must be below size+1, else the modulo wrap fails
`default_nettype none
`timescale 1ns/1ns

module asg_sequencer #(
  parameter int unsigned ADDR_W = 6,
  parameter int unsigned FRAC_W = 8,
  parameter int unsigned CNT_W  = 16,
  parameter int unsigned TRG_N  = 2
) (
  input  logic                     sto,
  input  logic                     ctl_rst,
  input  logic                     advance,
  // trigger sources
  input  logic [TRG_N-1:0]         trg_in,
  input  logic [TRG_N-1:0]         trg_mask,
  input  logic                     sw_trig,
  input  logic                     stop,
  // settings
  input  logic [ADDR_W+FRAC_W-1:0] siz,
  input  logic [ADDR_W+FRAC_W-1:0] stp,
  input  logic [ADDR_W+FRAC_W-1:0] off,
  input  logic                     burst_en,
  input  logic                     infinite,
  input  logic [CNT_W-1:0]         bdl,
  input  logic [CNT_W-1:0]         bln,
  input  logic [CNT_W-1:0]         bnm,
  // table request
  output logic [ADDR_W-1:0]        rd_addr,
  output logic                     rd_en,
  output logic                     beat_vld,
  output logic                     beat_last,
  // status
  output logic                     trg_out,
  output logic                     running,
  output logic [CNT_W-1:0]         rep_cnt
);

  localparam int unsigned PW = ADDR_W + FRAC_W;

  logic          clr;
  logic          trg_start;
  logic          trg_rpt;
  logic          trg_ev;
  logic          end_bdl;
  logic          end_bln;
  logic          end_bnm;
  logic          aen;
  logic [CNT_W-1:0] bln_cnt;
  logic [PW-1:0] ptr;
  logic [PW+1:0] ptr_add;
  logic [PW+1:0] ptr_sub;

  // stop clears like reset
  assign clr = ctl_rst | stop;

  //////////////////////////////
  // trigger and counters
  //////////////////////////////

  // start only while idle, later triggers ignored
  assign trg_start = ~running & (sw_trig | (|(trg_in & trg_mask)));
  // burst period restart
  assign trg_rpt   = running & burst_en & end_bln;
  assign trg_ev    = trg_start | trg_rpt;

  assign end_bdl = bln_cnt == bdl;
  assign end_bln = bln_cnt == bln;
  assign end_bnm = (rep_cnt == bnm) & ~infinite;

  // burst FSM, period counter and repetitions
  always_ff @(posedge sto) begin
    if (clr) begin
      aen     <= 1'b0;
      running <= 1'b0;
      bln_cnt <= '0;
      rep_cnt <= '0;
    end else if (advance) begin
      if (trg_start) begin
        aen     <= 1'b1;
        running <= 1'b1;
        bln_cnt <= '0;
        rep_cnt <= '0;
      end else if (trg_rpt) begin
        // last period ends the run
        aen     <= ~end_bnm;
        running <= ~end_bnm;
        bln_cnt <= '0;
        rep_cnt <= rep_cnt + 1'b1;
      end else if (burst_en && running) begin
        if (end_bdl) begin
          aen <= 1'b0;
        end
        bln_cnt <= bln_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////
  // read pointer
  //////////////////////////////

  // two guard bits, the top one is the sign after subtraction
  assign ptr_add = {2'b00, ptr} + {2'b00, stp} + 1'b1;
  assign ptr_sub = ptr_add - ({2'b00, siz} + 1'b1);

  always_ff @(posedge sto) begin
    if (clr) begin
      ptr <= '0;
    end else if (advance) begin
      if (trg_ev) begin
        ptr <= off;
      end else if (aen) begin
        // wrap when past size+1
        ptr <= ptr_sub[PW+1] ? ptr_add[PW-1:0] : ptr_sub[PW-1:0];
      end
    end
  end

  //////////////////////////////
  // address stage
  //////////////////////////////

  // integer part of the pointer
  always_ff @(posedge sto) begin
    if (advance && aen) begin
      rd_addr <= ptr[FRAC_W +: ADDR_W];
    end
  end

  always_ff @(posedge sto) begin
    if (clr) begin
      rd_en     <= 1'b0;
      beat_vld  <= 1'b0;
      beat_last <= 1'b0;
      trg_out   <= 1'b0;
    end else begin
      // trigger notice for a start that was taken
      trg_out <= trg_start & advance;
      if (advance) begin
        rd_en     <= aen;
        beat_vld  <= running;
        beat_last <= trg_rpt & end_bnm;
      end
    end
  end

endmodule : asg_sequencer

`default_nettype wire

// ==== rtl/asg_top.sv ====
// one channel, host and stream on sto; stop flushes every pipeline stage
`default_nettype none
`timescale 1ns/1ns

module asg_top #(
  parameter int unsigned ADDR_W = 6,
  parameter int unsigned FRAC_W = 8,
  parameter int unsigned CNT_W  = 16,
  parameter int unsigned TRG_N  = 2
) (
  input  logic                       sto,
  input  logic                       ctl_rst,
  // APB
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [asg_pkg::APB_AW-1:0] paddr,
  input  logic [asg_pkg::APB_DW-1:0] pwdata,
  output logic [asg_pkg::APB_DW-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,
  // triggers
  input  logic [TRG_N-1:0]           trg_in,
  output logic                       trg_out,
  // stream
  input  logic                       tready,
  output asg_pkg::sample_t           tdata,
  output logic                       tvalid,
  output logic                       tlast,
  output logic                       done
);

  import asg_pkg::*;

  //////////////////////////////
  // wires
  //////////////////////////////

  logic [ADDR_W+FRAC_W-1:0] siz;
  logic [ADDR_W+FRAC_W-1:0] stp;
  logic [ADDR_W+FRAC_W-1:0] off;
  logic                     burst_en;
  logic                     infinite;
  logic [CNT_W-1:0]         bdl;
  logic [CNT_W-1:0]         bln;
  logic [CNT_W-1:0]         bnm;
  logic [TRG_N-1:0]         trg_mask;
  logic                     sw_trig;
  logic                     stop;
  logic                     running;
  logic [CNT_W-1:0]         rep_cnt;
  // table write
  logic                     tbl_we;
  logic [ADDR_W-1:0]        tbl_waddr;
  sample_t                  tbl_wdata;
  // pipeline
  logic [ADDR_W-1:0]        rd_addr;
  logic                     rd_en;
  logic                     beat_vld;
  logic                     beat_last;
  sample_t                  rd_data;
  logic                     data_vld;
  logic                     data_last;
  logic                     advance;

  //////////////////////////////
  // instances
  //////////////////////////////

  asg_apb_regs #(
    .ADDR_W (ADDR_W),
    .FRAC_W (FRAC_W),
    .CNT_W  (CNT_W),
    .TRG_N  (TRG_N)
  ) asg_apb_regs_inst (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .running   (running),
    .rep_cnt   (rep_cnt),
    .siz       (siz),
    .stp       (stp),
    .off       (off),
    .burst_en  (burst_en),
    .infinite  (infinite),
    .bdl       (bdl),
    .bln       (bln),
    .bnm       (bnm),
    .trg_mask  (trg_mask),
    .sw_trig   (sw_trig),
    .stop      (stop),
    .tbl_we    (tbl_we),
    .tbl_waddr (tbl_waddr),
    .tbl_wdata (tbl_wdata)
  );

  asg_sequencer #(
    .ADDR_W (ADDR_W),
    .FRAC_W (FRAC_W),
    .CNT_W  (CNT_W),
    .TRG_N  (TRG_N)
  ) asg_sequencer_inst (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .advance   (advance),
    .trg_in    (trg_in),
    .trg_mask  (trg_mask),
    .sw_trig   (sw_trig),
    .stop      (stop),
    .siz       (siz),
    .stp       (stp),
    .off       (off),
    .burst_en  (burst_en),
    .infinite  (infinite),
    .bdl       (bdl),
    .bln       (bln),
    .bnm       (bnm),
    .rd_addr   (rd_addr),
    .rd_en     (rd_en),
    .beat_vld  (beat_vld),
    .beat_last (beat_last),
    .trg_out   (trg_out),
    .running   (running),
    .rep_cnt   (rep_cnt)
  );

  // descriptor also flushed by stop, no stale beat after a stop
  asg_table #(
    .ADDR_W (ADDR_W)
  ) asg_table_inst (
    .sto       (sto),
    .ctl_rst   (ctl_rst | stop),
    .advance   (advance),
    .tbl_we    (tbl_we),
    .tbl_waddr (tbl_waddr),
    .tbl_wdata (tbl_wdata),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .beat_vld  (beat_vld),
    .beat_last (beat_last),
    .rd_data   (rd_data),
    .data_vld  (data_vld),
    .data_last (data_last)
  );

  asg_stream_out asg_stream_out_inst (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .stop      (stop),
    .rd_data   (rd_data),
    .data_vld  (data_vld),
    .data_last (data_last),
    .tready    (tready),
    .tdata     (tdata),
    .tvalid    (tvalid),
    .tlast     (tlast),
    .done      (done),
    .advance   (advance)
  );

endmodule : asg_top

`default_nettype wire

// ==== bench/asg_properties.sv ====
// handshake rules at the stream output stage; a stop flush may change the payload while stalled
`default_nettype none
`timescale 1ns/1ns

module asg_properties (
  input logic             sto,
  input logic             ctl_rst,
  input logic             stop,
  input logic             tready,
  input asg_pkg::sample_t tdata,
  input logic             tvalid,
  input logic             tlast
);

  //////////////////////////////
  // stream rules
  //////////////////////////////

  // payload frozen while the sink stalls
  stall_stable: assert property (@(posedge sto) disable iff (ctl_rst || stop)
    (tvalid && !tready) |=> ($stable(tdata) && $stable(tlast)))
    else $error("tdata or tlast changed while tvalid was stalled");

  // nothing offered right after reset
  reset_idle: assert property (@(posedge sto) ctl_rst |=> !tvalid)
    else $error("tvalid high in the cycle after reset");

  // last marker only on a valid beat
  last_valid: assert property (@(posedge sto) disable iff (ctl_rst) tlast |-> tvalid)
    else $error("tlast high without tvalid");

endmodule : asg_properties

`default_nettype wire

// ==== bench/asg_tb.sv ====
// single clock testbench for asg_top at default parameters; table fill and tready come from an LFSR
`default_nettype none
`timescale 1ns/1ns

module asg_tb;

  import asg_pkg::*;

  localparam int ADDR_W = 6;
  localparam int FRAC_W = 8;
  localparam int CNT_W  = 16;
  localparam int TRG_N  = 2;

  // beats per test in run order from periodic to ext trigger
  localparam int TEST_BEATS  = 100 + 60 + 30 + 50 + 100 + 10;
  // table fill plus register traffic at three cycles per access
  localparam int APB_CYC     = 140 * 3;
  localparam int TIMEOUT_CYC = TEST_BEATS * 4 + APB_CYC + 500;

  logic                 sto = 1'b0;
  logic                 ctl_rst;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [APB_AW-1:0]    paddr;
  logic [APB_DW-1:0]    pwdata;
  logic [APB_DW-1:0]    prdata;
  logic                 pready;
  logic                 pslverr;
  logic [TRG_N-1:0]     trg_in;
  logic                 trg_out;
  logic                 tready;
  sample_t              tdata;
  logic                 tvalid;
  logic                 tlast;
  logic                 done;

  // host side model of the table
  sample_t     tbl_model [0:2**ADDR_W-1];
  logic [31:0] lfsr_state = 32'ha9aa_cfa9;
  // settings as seen by the reference
  int          cfg_siz;
  int          cfg_stp;
  int          cfg_off;
  int          cfg_bdl;
  int          cfg_bln;
  int          cfg_bnm;
  bit          cfg_burst;
  bit          cfg_inf;
  // compare process counters
  int          beat_n = 0;
  int          trg_cnt = 0;
  int          done_cnt = 0;
  int          beat_errs = 0;
  // main process bookkeeping
  int          beat_base = 0;
  int          main_errs = 0;
  int          test_cnt = 0;
  int          failed_tests = 0;
  int          test_errs0;
  string       test_name;
  bit          bp_on = 1'b0;
  int          cyc_cnt = 0;

  asg_top #(
    .ADDR_W (ADDR_W),
    .FRAC_W (FRAC_W),
    .CNT_W  (CNT_W),
    .TRG_N  (TRG_N)
  ) asg_top_inst (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .trg_in  (trg_in),
    .trg_out (trg_out),
    .tready  (tready),
    .tdata   (tdata),
    .tvalid  (tvalid),
    .tlast   (tlast),
    .done    (done)
  );

  bind asg_stream_out asg_properties asg_properties_inst (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .stop    (stop),
    .tready  (tready),
    .tdata   (tdata),
    .tvalid  (tvalid),
    .tlast   (tlast)
  );

  // 20 ns period
  always #10 sto = ~sto;

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] want, inout int errs);
    if (got !== want) begin
      $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
      errs = errs + 1;
    end
  endtask

  // galois form with taps x^32+x^22+x^2+x+1
  function automatic logic lfsr_step();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
    return r;
  endfunction

  // expected {last, table index} of beat n after the trigger
  function automatic logic [ADDR_W:0] expect_beat(input int n);
    int  pos;
    int  steps;
    int  p;
    logic last;
    last  = 1'b0;
    steps = n;
    if (cfg_burst) begin
      pos   = n % (cfg_bln + 1);
      // idle part of a period holds the last data sample
      steps = (pos > cfg_bdl) ? cfg_bdl : pos;
      last  = !cfg_inf && (n / (cfg_bln + 1) == cfg_bnm) && (pos == cfg_bln);
    end
    p = cfg_off;
    for (int i = 0; i < steps; i++) begin
      p = p + cfg_stp + 1;
      if (p >= cfg_siz + 1) p = p - (cfg_siz + 1);
    end
    return {last, p[FRAC_W +: ADDR_W]};
  endfunction

  //////////////////////////////
  // APB tasks
  //////////////////////////////

  task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge sto);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    // no ready in the setup phase
    @(posedge sto);
    compare("pready", 32'(pready), 32'd0, main_errs);
    @(negedge sto);
    penable = 1'b1;
    // pre-edge values of the access phase
    @(posedge sto);
    rdata = prdata;
    err   = pslverr;
    compare("pready", 32'(pready), 32'd1, main_errs);
    @(negedge sto);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    compare("pslverr", 32'(err), 32'd0, main_errs);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'd0, data, err);
    compare("pslverr", 32'(err), 32'd0, main_errs);
  endtask

  task automatic check_field(input logic [APB_AW-1:0] addr, input logic [31:0] wdata,
                             input logic [31:0] want);
    logic [31:0] rd;
    apb_write(addr, wdata);
    apb_read(addr, rd);
    compare("prdata", rd, want, main_errs);
  endtask

  //////////////////////////////
  // run control
  //////////////////////////////

  task automatic configure(input int siz, stp, off, bdl, bln, bnm, input bit burst, inf);
    cfg_siz   = siz;
    cfg_stp   = stp;
    cfg_off   = off;
    cfg_bdl   = bdl;
    cfg_bln   = bln;
    cfg_bnm   = bnm;
    cfg_burst = burst;
    cfg_inf   = inf;
    apb_write(REG_SIZ, 32'(siz));
    apb_write(REG_STP, 32'(stp));
    apb_write(REG_OFF, 32'(off));
    apb_write(REG_BDL, 32'(bdl));
    apb_write(REG_BLN, 32'(bln));
    apb_write(REG_BNM, 32'(bnm));
  endtask

  task automatic start_run(input logic [31:0] ctrl);
    beat_base = beat_n;
    apb_write(REG_CTRL, ctrl);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge sto);
  endtask

  // random tready only while bp_on
  task automatic wait_beats(input int n);
    while (beat_n - beat_base < n) begin
      @(negedge sto);
      if (bp_on) tready = lfsr_step();
      else tready = 1'b1;
    end
  endtask

  task automatic stop_run();
    logic [31:0] rd;
    apb_write(REG_CTRL, 32'h2);
    idle_cycles(3);
    compare("tvalid", 32'(tvalid), 32'd0, main_errs);
    apb_read(REG_STATUS, rd);
    compare("running", 32'(rd[0]), 32'd0, main_errs);
  endtask

  task automatic pulse_trigger(input logic [TRG_N-1:0] lines);
    @(negedge sto);
    trg_in = lines;
    @(negedge sto);
    trg_in = '0;
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    test_cnt   = test_cnt + 1;
    test_errs0 = main_errs + beat_errs;
  endtask

  task automatic end_test();
    int d;
    d = main_errs + beat_errs - test_errs0;
    if (d == 0) begin
      $display("test %0d %s: ok", test_cnt, test_name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_cnt, test_name, d);
      failed_tests = failed_tests + 1;
    end
  endtask

  //////////////////////////////
  // beat checker
  //////////////////////////////

  always @(posedge sto) begin : compare_beats
    logic [ADDR_W:0] want;
    if (!ctl_rst) begin
      if (trg_out) trg_cnt = trg_cnt + 1;
      if (tvalid && tready) begin
        want = expect_beat(beat_n - beat_base);
        compare("tdata", 32'(tdata), 32'(tbl_model[want[ADDR_W-1:0]]), beat_errs);
        compare("tlast", 32'(tlast), 32'(want[ADDR_W]), beat_errs);
        compare("done", 32'(done), 32'(want[ADDR_W]), beat_errs);
        if (done) done_cnt = done_cnt + 1;
        beat_n = beat_n + 1;
      end
    end
  end

  // hang guard
  always @(posedge sto) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : main
    logic [31:0] rd;
    logic [31:0] r;
    logic        err;
    int          trg0;
    int          done0;
    ctl_rst = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    trg_in  = '0;
    tready  = 1'b1;
    repeat (4) @(posedge sto);
    @(negedge sto);
    ctl_rst = 1'b0;

    begin_test("reset and registers");
    compare("tvalid", 32'(tvalid), 32'd0, main_errs);
    compare("tlast", 32'(tlast), 32'd0, main_errs);
    compare("trg_out", 32'(trg_out), 32'd0, main_errs);
    compare("done", 32'(done), 32'd0, main_errs);
    compare("pslverr", 32'(pslverr), 32'd0, main_errs);
    apb_read(REG_STATUS, rd);
    compare("running", 32'(rd[0]), 32'd0, main_errs);
    // fields masked to their widths
    check_field(REG_SIZ, 32'hffff_ffff, 32'h0000_3fff);
    check_field(REG_STP, 32'h1234_5678, 32'h0000_1678);
    check_field(REG_BDL, 32'hdead_beef, 32'h0000_beef);
    check_field(REG_TRG_MASK, 32'hffff_ffff, 32'h0000_0003);
    check_field(REG_CTRL, 32'h0000_000c, 32'h0000_000c);
    apb_write(REG_CTRL, 32'h0);
    apb_access(1'b0, 12'h024, 32'd0, rd, err);
    compare("pslverr", 32'(err), 32'd1, main_errs);
    apb_access(1'b1, 12'h040, 32'd0, rd, err);
    compare("pslverr", 32'(err), 32'd1, main_errs);
    // table window is write only
    apb_access(1'b0, TABLE_BASE, 32'd0, rd, err);
    compare("pslverr", 32'(err), 32'd1, main_errs);
    end_test();

    begin_test("periodic integer step");
    for (int i = 0; i < 2**ADDR_W; i++) begin
      r = rand_bits(14);
      tbl_model[i] = r[13:0];
      apb_write(TABLE_BASE + 12'(4 * i), r);
    end
    // full table at step 3
    configure(32'h3fff, 32'h2ff, 0, 0, 0, 0, 1'b0, 1'b0);
    trg0 = trg_cnt;
    start_run(32'h1);
    wait_beats(100);
    stop_run();
    compare("trg_out count", 32'(trg_cnt - trg0), 32'd1, main_errs);
    end_test();

    begin_test("fractional step and retrigger");
    // 45 entries with step 1.5 and offset 10.5
    configure(32'h2cff, 32'h17f, 32'ha80, 0, 0, 0, 1'b0, 1'b0);
    trg0 = trg_cnt;
    start_run(32'h1);
    wait_beats(20);
    // ignored while running
    apb_write(REG_CTRL, 32'h1);
    wait_beats(60);
    stop_run();
    compare("trg_out count", 32'(trg_cnt - trg0), 32'd1, main_errs);
    end_test();

    begin_test("burst");
    // 4 data beats per 10 beat period over 3 periods
    configure(32'h3fff, 32'hff, 32'h500, 3, 9, 2, 1'b1, 1'b0);
    done0 = done_cnt;
    start_run(32'h5);
    wait_beats(30);
    idle_cycles(8);
    compare("beat count", 32'(beat_n - beat_base), 32'd30, main_errs);
    compare("done count", 32'(done_cnt - done0), 32'd1, main_errs);
    compare("tvalid", 32'(tvalid), 32'd0, main_errs);
    apb_read(REG_STATUS, rd);
    compare("running", 32'(rd[0]), 32'd0, main_errs);
    compare("rep_cnt", 32'(rd[31:16]), 32'd3, main_errs);
    // infinite keeps going past bnm+1 periods
    cfg_inf = 1'b1;
    done0 = done_cnt;
    start_run(32'hd);
    wait_beats(50);
    apb_read(REG_STATUS, rd);
    compare("running", 32'(rd[0]), 32'd1, main_errs);
    compare("done count", 32'(done_cnt - done0), 32'd0, main_errs);
    stop_run();
    end_test();

    begin_test("back-pressure");
    configure(32'h3fff, 32'h2ff, 0, 0, 0, 0, 1'b0, 1'b0);
    bp_on = 1'b1;
    start_run(32'h1);
    wait_beats(100);
    bp_on  = 1'b0;
    stop_run();
    tready = 1'b1;
    end_test();

    begin_test("external trigger");
    // 2 data beats in one 5 beat period
    configure(32'h3fff, 32'hff, 0, 1, 4, 0, 1'b1, 1'b0);
    apb_write(REG_TRG_MASK, 32'h1);
    apb_write(REG_CTRL, 32'h4);
    trg0  = trg_cnt;
    done0 = done_cnt;
    beat_base = beat_n;
    // masked line
    pulse_trigger(2'b10);
    idle_cycles(10);
    compare("beat count", 32'(beat_n - beat_base), 32'd0, main_errs);
    compare("trg_out count", 32'(trg_cnt - trg0), 32'd0, main_errs);
    pulse_trigger(2'b01);
    wait_beats(5);
    idle_cycles(8);
    compare("beat count", 32'(beat_n - beat_base), 32'd5, main_errs);
    compare("trg_out count", 32'(trg_cnt - trg0), 32'd1, main_errs);
    beat_base = beat_n;
    pulse_trigger(2'b01);
    wait_beats(5);
    idle_cycles(8);
    compare("trg_out count", 32'(trg_cnt - trg0), 32'd2, main_errs);
    compare("done count", 32'(done_cnt - done0), 32'd2, main_errs);
    end_test();

    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             test_cnt, failed_tests, main_errs + beat_errs);
    if (main_errs + beat_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : asg_tb

`default_nettype wire

// ==== sources.f ====
rtl/asg_pkg.sv
rtl/asg_table.sv
rtl/asg_stream_out.sv
rtl/asg_apb_regs.sv
rtl/asg_sequencer.sv
rtl/asg_top.sv
bench/asg_properties.sv
bench/asg_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the asg testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module asg_tb -f sources.f \
  --Mdir obj_dir -o asg_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/asg_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
